/* rtl/zoom_pkg.sv */
package zoom_pkg;

    // ====================
    // Frame geometry
    // ====================
    localparam int frame_w      = 32;
    localparam int frame_h      = 24;
    localparam int frame_pixels = frame_w * frame_h;

    localparam int addr_bits  = 10;     // Covers frame_pixels
    localparam int coord_bits = 6;

    // ====================
    // Types
    // ====================

    // 8-bit grey level
    typedef logic [7:0] pixel_t;

    // Linear address, y * frame_w + x
    typedef logic [addr_bits-1:0] pix_addr_t;

    typedef logic [coord_bits-1:0] coord_t;

    // Host command codes
    typedef enum logic [2:0] {
        op_nop      = 3'd0,
        op_load     = 3'd1,
        op_store    = 3'd2,
        op_zoom_in  = 3'd3,     // Centre quarter to full frame
        op_zoom_out = 3'd4,     // Full frame to centre half
        op_restore  = 3'd5
    } zoom_op_t;

endpackage

/* rtl/mem_port_if.sv */
`timescale 1ns/1ps

interface mem_port_if import zoom_pkg::*; ();

    pix_addr_t rd_addr;
    pixel_t    rd_data;     // Valid one cycle after rd_addr
    logic      wr_en;
    pix_addr_t wr_addr;
    pixel_t    wr_data;

    modport reader (output rd_addr, input rd_data);
    modport writer (output wr_en, wr_addr, wr_data);
    modport memory (input rd_addr, wr_en, wr_addr, wr_data, output rd_data);

    // Both halves, for the owner of the original image
    modport controller (output rd_addr, wr_en, wr_addr, wr_data, input rd_data);

    // Read half seen from the memory side
    modport src_mem (input rd_addr, output rd_data);

endinterface

/* rtl/frame_mem.sv */
`timescale 1ns/1ps

module frame_mem import zoom_pkg::*; (
    mem_port_if.memory mem,
    input  logic       clk_100
);

    pixel_t ram [frame_pixels];

    always_ff @(posedge clk_100) begin
        if (mem.wr_en) begin
            ram[mem.wr_addr] <= mem.wr_data;
        end
        mem.rd_data <= ram[mem.rd_addr];    // Registered read
    end

    // ====================
    // Checks
    // ====================

    // Writers do their own range checks upstream
    a_wr_in_range: assert property (@(posedge clk_100)
        mem.wr_en |-> (mem.wr_addr < pix_addr_t'(frame_pixels)));

endmodule

/* rtl/zoom_engine.sv */
`timescale 1ns/1ps

module zoom_engine import zoom_pkg::*; (
    input  logic       clk_100,
    input  logic       arst_n,
    input  logic       start,
    input  logic       zoom_in,
    output logic       done,
    mem_port_if.reader src,
    mem_port_if.writer dst
);

    typedef enum logic [1:0] {
        st_idle,
        st_in,      // One pixel per cycle
        st_out,     // Four reads per inner pixel
        st_last
    } eng_state_t;

    eng_state_t state;
    coord_t     x;
    coord_t     y;
    logic [1:0] ph;         // Position inside the 2x2 block
    logic [9:0] acc;
    logic [9:0] sum;
    logic       inner;
    logic       last_px;
    logic       px_done;
    logic       wr_pend;
    logic       wr_zero;
    logic       wr_avg;
    pix_addr_t  wr_addr_q;

    function automatic pix_addr_t xy_addr(input int unsigned px, input int unsigned py);
        return pix_addr_t'(py * frame_w + px);
    endfunction

    // ====================
    // Scan position
    // ====================
    assign inner = (x >= coord_t'(frame_w / 4)) && (x < coord_t'(3 * frame_w / 4))
                && (y >= coord_t'(frame_h / 4)) && (y < coord_t'(3 * frame_h / 4));

    assign last_px = (x == coord_t'(frame_w - 1)) && (y == coord_t'(frame_h - 1));

    // Output pixel finishes its reads this cycle
    assign px_done = (state == st_in) || (state == st_out && (!inner || ph == 2'd3));

    always_comb begin
        if (state == st_in) begin
            src.rd_addr = xy_addr(x / 2 + frame_w / 4, y / 2 + frame_h / 4);
        end else if (state == st_out && inner) begin
            src.rd_addr = xy_addr(2 * (x - frame_w / 4) + ph[0],
                                  2 * (y - frame_h / 4) + ph[1]);
        end else begin
            src.rd_addr = '0;
        end
    end

    // ====================
    // Write side
    // ====================
    assign sum         = acc + {2'b00, src.rd_data};
    assign dst.wr_en   = wr_pend;
    assign dst.wr_addr = wr_addr_q;
    assign dst.wr_data = wr_zero ? '0 : (wr_avg ? sum[9:2] : src.rd_data);

    always_ff @(posedge clk_100 or negedge arst_n) begin
        if (!arst_n) begin
            state   <= st_idle;
            x       <= '0;
            y       <= '0;
            ph      <= '0;
            wr_pend <= 1'b0;
            done    <= 1'b0;
        end else begin
            done    <= 1'b0;
            wr_pend <= 1'b0;
            case (state)
                st_idle: begin
                    if (start) begin
                        x     <= '0;
                        y     <= '0;
                        ph    <= '0;
                        state <= zoom_in ? st_in : st_out;
                    end
                end
                st_in, st_out: begin
                    if (state == st_out && inner) begin
                        ph <= ph + 2'd1;        // Wraps after the fourth read
                    end
                    if (px_done) begin
                        wr_pend <= 1'b1;
                        if (x == coord_t'(frame_w - 1)) begin
                            x <= '0;
                            y <= y + 1'b1;
                        end else begin
                            x <= x + 1'b1;
                        end
                        if (last_px) begin
                            state <= st_last;
                        end
                    end
                end
                st_last: begin
                    state <= st_idle;   // Final write goes out this cycle
                    done  <= 1'b1;
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk_100) begin
        wr_addr_q <= xy_addr(x, y);
        wr_zero   <= (state == st_out) && !inner;
        wr_avg    <= (state == st_out);
        acc       <= (state == st_out && inner && ph != 2'd0) ? sum : '0;
    end

    // ====================
    // Checks
    // ====================
    a_start_idle: assert property (@(posedge clk_100) disable iff (!arst_n)
        start |-> (state == st_idle));

    a_done_pulse: assert property (@(posedge clk_100) disable iff (!arst_n)
        done |=> !done);

endmodule

/* rtl/zoom_ctrl.sv */
`timescale 1ns/1ps

module zoom_ctrl import zoom_pkg::*; (
    input  logic              clk_100,
    input  logic              arst_n,
    input  logic              cmd_valid,
    output logic              cmd_ready,
    input  zoom_op_t          cmd_op,
    input  pix_addr_t         cmd_addr,
    input  pixel_t            cmd_data,
    output logic              rsp_valid,
    output logic              rsp_err,
    output pixel_t            rsp_data,
    output logic              eng_start,
    output logic              eng_zoom_in,
    input  logic              eng_done,
    mem_port_if.controller    orig,
    mem_port_if.src_mem       eng_src,
    mem_port_if.reader        work,
    mem_port_if.writer        disp
);

    typedef enum logic [2:0] {
        st_idle,
        st_access,
        st_run,
        st_copy,
        st_respond
    } ctrl_state_t;

    ctrl_state_t state;
    zoom_op_t    op_q;
    pix_addr_t   addr_q;
    pixel_t      data_q;
    pix_addr_t   cnt;           // Copy read address
    pix_addr_t   cp_addr;
    logic        cp_pend;
    logic        copy_work;
    logic        in_range;

    assign in_range  = cmd_addr < pix_addr_t'(frame_pixels);
    assign copy_work = (op_q == op_zoom_in) || (op_q == op_zoom_out);
    assign cmd_ready = (state == st_idle);
    assign rsp_valid = (state == st_respond);

    // ====================
    // Memory ports
    // ====================
    always_comb begin
        case (state)
            st_run:  orig.rd_addr = eng_src.rd_addr;   // Engine owns the read port
            st_copy: orig.rd_addr = cnt;
            default: orig.rd_addr = cmd_addr;          // Load reads at handshake
        endcase
    end

    assign eng_src.rd_data = orig.rd_data;

    assign orig.wr_en   = (state == st_access) && (op_q == op_store);
    assign orig.wr_addr = addr_q;
    assign orig.wr_data = data_q;

    assign work.rd_addr = cnt;

    // Display write trails its read by one cycle
    assign disp.wr_en   = cp_pend;
    assign disp.wr_addr = cp_addr;
    assign disp.wr_data = copy_work ? work.rd_data : orig.rd_data;

    // ====================
    // Command FSM
    // ====================
    always_ff @(posedge clk_100 or negedge arst_n) begin
        if (!arst_n) begin
            state       <= st_idle;
            op_q        <= op_nop;
            cnt         <= '0;
            cp_pend     <= 1'b0;
            rsp_err     <= 1'b0;
            eng_start   <= 1'b0;
            eng_zoom_in <= 1'b0;
        end else begin
            eng_start <= 1'b0;
            cp_pend   <= (state == st_copy) && (cnt != pix_addr_t'(frame_pixels));
            case (state)
                st_idle: begin
                    if (cmd_valid) begin
                        op_q    <= cmd_op;
                        rsp_err <= 1'b0;
                        cnt     <= '0;
                        case (cmd_op)
                            op_load, op_store: begin
                                if (in_range) begin
                                    state <= st_access;
                                end else begin
                                    rsp_err <= 1'b1;    // Rejected, nothing written
                                    state   <= st_respond;
                                end
                            end
                            op_zoom_in, op_zoom_out: begin
                                eng_start   <= 1'b1;
                                eng_zoom_in <= (cmd_op == op_zoom_in);
                                state       <= st_run;
                            end
                            op_restore: state <= st_copy;
                            default:    state <= st_respond;
                        endcase
                    end
                end
                st_access: state <= (op_q == op_store) ? st_copy : st_respond;
                st_run: begin
                    if (eng_done) begin
                        state <= st_copy;
                    end
                end
                st_copy: begin
                    if (cnt == pix_addr_t'(frame_pixels)) begin
                        state <= st_respond;    // Last display write lands now
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                st_respond: state <= st_idle;
                default:    state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk_100) begin
        cp_addr <= cnt;
        if (state == st_idle) begin
            addr_q   <= cmd_addr;
            data_q   <= cmd_data;
            rsp_data <= '0;
        end else if (state == st_access && op_q == op_load) begin
            rsp_data <= orig.rd_data;
        end
    end

    // ====================
    // Checks
    // ====================
    a_rsp_pulse: assert property (@(posedge clk_100) disable iff (!arst_n)
        rsp_valid |=> !rsp_valid);

endmodule

/* rtl/zoom_top.sv */
`timescale 1ns/1ps

module zoom_top import zoom_pkg::*; (
    input  logic      clk_100,
    input  logic      arst_n,
    input  logic      cmd_valid,
    output logic      cmd_ready,
    input  zoom_op_t  cmd_op,
    input  pix_addr_t cmd_addr,
    input  pixel_t    cmd_data,
    output logic      rsp_valid,
    output logic      rsp_err,
    output pixel_t    rsp_data,
    input  pix_addr_t disp_addr,
    output pixel_t    disp_data
);

    logic eng_start;
    logic eng_zoom_in;
    logic eng_done;

    mem_port_if orig_bus ();
    mem_port_if eng_src ();
    mem_port_if work_bus ();
    mem_port_if disp_bus ();

    // Display read port, data one cycle after the address
    assign disp_bus.rd_addr = disp_addr;
    assign disp_data        = disp_bus.rd_data;

    // ====================
    // Control and engine
    // ====================
    zoom_ctrl ctrl0 (
        .clk_100     (clk_100),
        .arst_n      (arst_n),
        .cmd_valid   (cmd_valid),
        .cmd_ready   (cmd_ready),
        .cmd_op      (cmd_op),
        .cmd_addr    (cmd_addr),
        .cmd_data    (cmd_data),
        .rsp_valid   (rsp_valid),
        .rsp_err     (rsp_err),
        .rsp_data    (rsp_data),
        .eng_start   (eng_start),
        .eng_zoom_in (eng_zoom_in),
        .eng_done    (eng_done),
        .orig        (orig_bus),
        .eng_src     (eng_src),
        .work        (work_bus),
        .disp        (disp_bus)
    );

    zoom_engine engine0 (
        .clk_100 (clk_100),
        .arst_n  (arst_n),
        .start   (eng_start),
        .zoom_in (eng_zoom_in),
        .done    (eng_done),
        .src     (eng_src),
        .dst     (work_bus)
    );

    // ====================
    // Frame memories
    // ====================
    frame_mem orig_mem0 (    // Original image
        .mem     (orig_bus),
        .clk_100 (clk_100)
    );

    frame_mem work_mem0 (
        .mem     (work_bus),
        .clk_100 (clk_100)
    );

    frame_mem disp_mem0 (    // Display buffer
        .mem     (disp_bus),
        .clk_100 (clk_100)
    );

endmodule

/* dv/zoom_tb.sv */
`timescale 1ns/1ps

module zoom_tb import zoom_pkg::*; ();

    localparam int n_cmds      = 2 * frame_pixels + 10;     // Commands issued below
    localparam int cycle_limit = 40 * frame_pixels * n_cmds;

    logic      clk_100;
    logic      arst_n;
    logic      cmd_valid;
    logic      cmd_ready;
    zoom_op_t  cmd_op;
    pix_addr_t cmd_addr;
    pixel_t    cmd_data;
    logic      rsp_valid;
    logic      rsp_err;
    pixel_t    rsp_data;
    pix_addr_t disp_addr;
    pixel_t    disp_data;

    pixel_t    model [frame_pixels];    // Original image as the host wrote it
    pixel_t    load_expect;
    int        pending;                 // Taken commands still without response
    logic      zoom_busy;
    int        cycles = 0;

    logic      hs;
    logic      hs_load;
    logic      hs_bad;
    logic      hs_nop;

    zoom_top dut0 (
        .clk_100   (clk_100),
        .arst_n    (arst_n),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .cmd_op    (cmd_op),
        .cmd_addr  (cmd_addr),
        .cmd_data  (cmd_data),
        .rsp_valid (rsp_valid),
        .rsp_err   (rsp_err),
        .rsp_data  (rsp_data),
        .disp_addr (disp_addr),
        .disp_data (disp_data)
    );

    initial begin
        clk_100 = 1'b0;
        forever #2 clk_100 = ~clk_100;
    end

    always @(posedge clk_100) begin
        cycles = cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Timeout after %0d cycles, the DUT stopped answering", cycles);
            $display("STATUS: FAIL");
            $fatal(1, "Timeout");
        end
    end

    task automatic fail_now(input string msg);
        $display("Fail at %0t ns: %s", $time, msg);
        $display("STATUS: FAIL");
        $fatal(1, "Stopped at the first error");
    endtask

    // ====================
    // Reference model
    // ====================
    function automatic pixel_t expected_pixel(input zoom_op_t mode, input int a);
        int x;
        int y;
        int sx;
        int sy;
        int sum;
        x = a % frame_w;
        y = a / frame_w;
        case (mode)
            op_zoom_in: return model[(y / 2 + frame_h / 4) * frame_w + x / 2 + frame_w / 4];
            op_zoom_out: begin
                if (x < frame_w / 4 || x >= 3 * frame_w / 4
                    || y < frame_h / 4 || y >= 3 * frame_h / 4) begin
                    return '0;     // Border
                end
                sx  = 2 * (x - frame_w / 4);
                sy  = 2 * (y - frame_h / 4);
                sum = int'(model[sy * frame_w + sx]) + int'(model[sy * frame_w + sx + 1])
                    + int'(model[(sy + 1) * frame_w + sx])
                    + int'(model[(sy + 1) * frame_w + sx + 1]);
                return pixel_t'(sum / 4);
            end
            default: return model[a];
        endcase
    endfunction

    // ====================
    // Command driver
    // ====================
    task automatic send_cmd(input zoom_op_t op, input pix_addr_t addr, input pixel_t data);
        @(posedge clk_100);
        #1;
        cmd_valid = 1'b1;
        cmd_op    = op;
        cmd_addr  = addr;
        cmd_data  = data;
        if (addr < pix_addr_t'(frame_pixels)) begin
            if (op == op_load) begin
                load_expect = model[addr];
            end
            if (op == op_store) begin
                model[addr] = data;
            end
        end
        while (!cmd_ready) begin    // Held while the controller is busy
            @(posedge clk_100);
            #1;
        end
        @(posedge clk_100);         // Handshake edge
        #1;
        cmd_valid = 1'b0;
    endtask

    task automatic wait_rsp();
        while (!rsp_valid) begin
            @(posedge clk_100);
            #1;
        end
    endtask

    task automatic run_cmd(input zoom_op_t op, input pix_addr_t addr, input pixel_t data);
        send_cmd(op, addr, data);
        wait_rsp();
    endtask

    // Reads the whole display, one address per cycle
    task automatic check_display(input zoom_op_t mode);
        pixel_t exp;
        for (int i = 0; i <= frame_pixels; i++) begin
            @(posedge clk_100);
            #1;
            if (i > 0) begin
                exp = expected_pixel(mode, i - 1);
                assert (disp_data == exp) else fail_now($sformatf(
                    "%s display pixel %0d is %0h, expected %0h",
                    mode.name(), i - 1, disp_data, exp));
            end
            if (i < frame_pixels) begin
                disp_addr = pix_addr_t'(i);
            end
        end
    endtask

    // ====================
    // Response monitor
    // ====================
    assign hs      = cmd_valid && cmd_ready;
    assign hs_load = hs && (cmd_op == op_load) && (cmd_addr < pix_addr_t'(frame_pixels));
    assign hs_bad  = hs && (cmd_op == op_load || cmd_op == op_store)
                  && (cmd_addr >= pix_addr_t'(frame_pixels));
    assign hs_nop  = hs && (cmd_op == op_nop);

    always_ff @(posedge clk_100 or negedge arst_n) begin
        if (!arst_n) begin
            pending   <= 0;
            zoom_busy <= 1'b0;
        end else begin
            pending <= pending + (hs ? 1 : 0) - (rsp_valid ? 1 : 0);
            if (hs && (cmd_op == op_zoom_in || cmd_op == op_zoom_out)) begin
                zoom_busy <= 1'b1;
            end else if (rsp_valid) begin
                zoom_busy <= 1'b0;
            end
        end
    end

    a_rsp_has_cmd: assert property (@(posedge clk_100) disable iff (!arst_n)
        rsp_valid |-> (pending == 1)) else fail_now("response without a taken command");

    a_one_in_flight: assert property (@(posedge clk_100) disable iff (!arst_n)
        hs |-> (pending == 0)) else fail_now("command taken before the previous response");

    a_rsp_pulse: assert property (@(posedge clk_100) disable iff (!arst_n)
        rsp_valid |=> !rsp_valid) else fail_now("rsp_valid longer than one cycle");

    a_load_rsp: assert property (@(posedge clk_100) disable iff (!arst_n)
        $past(hs_load, 2) |-> rsp_valid && !rsp_err && (rsp_data == $past(load_expect, 2)))
        else fail_now("load response late or with wrong data");

    a_bad_rsp: assert property (@(posedge clk_100) disable iff (!arst_n)
        $past(hs_bad) |-> rsp_valid && rsp_err)
        else fail_now("out-of-range access not rejected one cycle later");

    a_err_cause: assert property (@(posedge clk_100) disable iff (!arst_n)
        (rsp_valid && rsp_err) |-> $past(hs_bad)) else fail_now("rsp_err on a valid command");

    a_nop_rsp: assert property (@(posedge clk_100) disable iff (!arst_n)
        $past(hs_nop) |-> rsp_valid && !rsp_err) else fail_now("nop response wrong");

    a_zoom_hold: assert property (@(posedge clk_100) disable iff (!arst_n)
        zoom_busy |-> !cmd_ready) else fail_now("cmd_ready high during a zoom");

    // ====================
    // Test sequence
    // ====================
    initial begin
        pixel_t    data;
        pix_addr_t held_addr;
        void'($urandom(72));
        arst_n      = 1'b0;
        cmd_valid   = 1'b0;
        cmd_op      = op_nop;
        cmd_addr    = '0;
        cmd_data    = '0;
        disp_addr   = '0;
        load_expect = '0;
        repeat (4) @(posedge clk_100);
        #1;
        arst_n = 1'b1;
        assert (cmd_ready && !rsp_valid) else fail_now("cmd_ready or rsp_valid wrong after reset");

        for (int a = 0; a < frame_pixels; a++) begin
            data = pixel_t'($urandom());
            run_cmd(op_store, pix_addr_t'(a), data);
            run_cmd(op_load, pix_addr_t'(a), '0);
        end
        check_display(op_store);

        run_cmd(op_load, pix_addr_t'(frame_pixels), '0);
        run_cmd(op_store, pix_addr_t'(frame_pixels + 5), ~model[5]);
        run_cmd(op_load, '1, '0);
        run_cmd(op_load, pix_addr_t'(5), '0);   // Untouched by the rejected store
        run_cmd(op_nop, '0, '0);

        run_cmd(op_restore, '0, '0);
        check_display(op_restore);
        run_cmd(op_zoom_in, '0, '0);
        check_display(op_zoom_in);

        // Load presented while zoom-out runs
        send_cmd(op_zoom_out, '0, '0);
        assert (!cmd_ready) else fail_now("cmd_ready high right after the zoom was taken");
        held_addr = pix_addr_t'($urandom_range(frame_pixels - 1));
        run_cmd(op_load, held_addr, '0);
        check_display(op_zoom_out);

        run_cmd(op_restore, '0, '0);
        check_display(op_restore);

        @(posedge clk_100);
        #1;
        assert (pending == 0) else fail_now("a response is missing at the end of the test");
        $display("STATUS: PASS");
        $finish;
    end

endmodule

/* zoom_top.f */
rtl/zoom_pkg.sv
rtl/mem_port_if.sv
rtl/frame_mem.sv
rtl/zoom_engine.sv
rtl/zoom_ctrl.sv
rtl/zoom_top.sv
dv/zoom_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the zoom testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -j 0 \
    --top-module zoom_tb -o zoom_sim \
    -f zoom_top.f > build.log 2>&1 \
    || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/zoom_sim > sim.log 2>&1 || echo "Simulator exited with an error"
cat sim.log

grep -q "STATUS: PASS" sim.log && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
